// ==== hdl/aesDataPkg.sv ====
package aesDataPkg;

  // One byte of the cipher state
  typedef logic [7:0] aesByte;

  // One column of four bytes, first byte in the top bits
  typedef logic [31:0] aesWord;

  // Full cipher state or data block
  // Byte 0 sits in the top 8 bits, bytes run column-major as in FIPS-197
  typedef logic [127:0] aesBlock;

  // Low byte of x^8 + x^4 + x^3 + x + 1
  localparam aesByte reductionPoly = 8'h1B;

  // Additive constant of the S-box affine transform
  localparam aesByte affineConst = 8'h63;

  // Multiply by x in GF(2^8)
  function automatic aesByte xtime(input aesByte b);
    aesByte shifted;
    shifted = {b[6:0], 1'b0};
    if (b[7]) begin
      xtime = shifted ^ reductionPoly;
    end else begin
      xtime = shifted;
    end
  endfunction

endpackage

// ==== hdl/aesKeyPkg.sv ====
package aesKeyPkg;

  // Cipher key, same byte order as the data block
  typedef logic [127:0] aesKey;

  // Round number, 0 to 10
  typedef logic [3:0] roundIdx;

  // AES-128 round count
  localparam roundIdx numRounds = 4'd10;

  // First rcon value, doubled once per round
  localparam aesDataPkg::aesByte rconInit = 8'h01;

  // Round sequencing of the encryption core
  typedef enum logic {
    stIdle,
    stRun
  } coreState;

endpackage

// ==== hdl/aesSbox.sv ====
`timescale 1ns/1ns

module aesSbox (
  input  aesDataPkg::aesByte inByte,
  output aesDataPkg::aesByte outByte
);

  aesDataPkg::aesByte x2;
  aesDataPkg::aesByte x3;
  aesDataPkg::aesByte x6;
  aesDataPkg::aesByte x12;
  aesDataPkg::aesByte x14;
  aesDataPkg::aesByte x15;
  aesDataPkg::aesByte x30;
  aesDataPkg::aesByte x60;
  aesDataPkg::aesByte x120;
  aesDataPkg::aesByte x240;
  aesDataPkg::aesByte inv;

  // Shift-and-add product in GF(2^8)
  function automatic aesDataPkg::aesByte gfMul(input aesDataPkg::aesByte a,
                                               input aesDataPkg::aesByte b);
    aesDataPkg::aesByte acc;
    aesDataPkg::aesByte p;
    acc = 8'h00;
    p = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ p;
      end
      p = aesDataPkg::xtime(p);
    end
    gfMul = acc;
  endfunction

  // Inverse as x^254, zero falls out as zero
  assign x2   = gfMul(inByte, inByte);
  assign x3   = gfMul(x2, inByte);
  assign x6   = gfMul(x3, x3);
  assign x12  = gfMul(x6, x6);
  assign x14  = gfMul(x12, x2);
  assign x15  = gfMul(x12, x3);
  assign x30  = gfMul(x15, x15);
  assign x60  = gfMul(x30, x30);
  assign x120 = gfMul(x60, x60);
  assign x240 = gfMul(x120, x120);
  assign inv  = gfMul(x240, x14);

  // Affine step, inverse XOR its four left rotations
  assign outByte = inv
                 ^ {inv[6:0], inv[7]}
                 ^ {inv[5:0], inv[7:6]}
                 ^ {inv[4:0], inv[7:5]}
                 ^ {inv[3:0], inv[7:4]}
                 ^ aesDataPkg::affineConst;

endmodule

// ==== hdl/aesRoundFunc.sv ====
`timescale 1ns/1ns

module aesRoundFunc (
  input  aesDataPkg::aesBlock stateIn,
  input  aesDataPkg::aesBlock roundKey,
  input  logic                lastRound,
  output aesDataPkg::aesBlock stateOut
);

  aesDataPkg::aesByte  inBytes [16];
  aesDataPkg::aesByte  subBytes [16];
  aesDataPkg::aesBlock shiftedBlock;
  aesDataPkg::aesBlock mixedBlock;

  // Multiply one column by the fixed MixColumns matrix
  function automatic aesDataPkg::aesWord mixColumn(input aesDataPkg::aesWord col);
    aesDataPkg::aesByte s0;
    aesDataPkg::aesByte s1;
    aesDataPkg::aesByte s2;
    aesDataPkg::aesByte s3;
    aesDataPkg::aesByte x0;
    aesDataPkg::aesByte x1;
    aesDataPkg::aesByte x2;
    aesDataPkg::aesByte x3;
    s0 = col[31:24];
    s1 = col[23:16];
    s2 = col[15:8];
    s3 = col[7:0];
    x0 = aesDataPkg::xtime(s0);
    x1 = aesDataPkg::xtime(s1);
    x2 = aesDataPkg::xtime(s2);
    x3 = aesDataPkg::xtime(s3);
    // 3*s is xtime(s) ^ s
    mixColumn = {x0 ^ x1 ^ s1 ^ s2 ^ s3,
                 s0 ^ x1 ^ x2 ^ s2 ^ s3,
                 s0 ^ s1 ^ x2 ^ x3 ^ s3,
                 x0 ^ s0 ^ s1 ^ s2 ^ x3};
  endfunction

  for (genvar k = 0; k < 16; k++) begin : gByte
    assign inBytes[k] = stateIn[127 - 8 * k -: 8];

    aesSbox sbox_i (
      .inByte (inBytes[k]),
      .outByte(subBytes[k])
    );

    // Byte k is row k%4 of column k/4, row r rotates left by r
    assign shiftedBlock[127 - 8 * k -: 8] =
      subBytes[(k % 4) + 4 * (((k / 4) + (k % 4)) % 4)];
  end

  for (genvar c = 0; c < 4; c++) begin : gColumn
    assign mixedBlock[127 - 32 * c -: 32] = mixColumn(shiftedBlock[127 - 32 * c -: 32]);
  end

  // Final round has no MixColumns
  assign stateOut = (lastRound ? shiftedBlock : mixedBlock) ^ roundKey;

endmodule

// ==== hdl/aesKeyExpand.sv ====
`timescale 1ns/1ns

module aesKeyExpand (
  input  logic                clk,
  input  logic                rst,
  input  logic                load,
  input  logic                advance,
  input  aesKeyPkg::aesKey    cipherKey,
  output aesDataPkg::aesBlock nextRoundKey
);

  aesKeyPkg::aesKey   keyReg;
  aesDataPkg::aesByte rconReg;
  aesDataPkg::aesWord curWord [4];
  aesDataPkg::aesWord newWord [4];
  aesDataPkg::aesWord rotWord;
  aesDataPkg::aesWord subWord;
  aesDataPkg::aesWord mixWord;

  for (genvar i = 0; i < 4; i++) begin : gWord
    assign curWord[i] = keyReg[127 - 32 * i -: 32];
  end

  // RotWord on the last word of the current key
  assign rotWord = {curWord[3][23:0], curWord[3][31:24]};

  for (genvar i = 0; i < 4; i++) begin : gSubWord
    aesSbox sbox_i (
      .inByte (rotWord[31 - 8 * i -: 8]),
      .outByte(subWord[31 - 8 * i -: 8])
    );
  end

  assign mixWord = subWord ^ {rconReg, 24'h000000};

  // Each new word chains on the one before it
  assign newWord[0] = curWord[0] ^ mixWord;
  assign newWord[1] = curWord[1] ^ newWord[0];
  assign newWord[2] = curWord[2] ^ newWord[1];
  assign newWord[3] = curWord[3] ^ newWord[2];

  assign nextRoundKey = {newWord[0], newWord[1], newWord[2], newWord[3]};

  always_ff @(posedge clk) begin
    if (rst) begin
      rconReg <= aesKeyPkg::rconInit;
    end else if (load) begin
      keyReg  <= cipherKey;
      rconReg <= aesKeyPkg::rconInit;
    end else if (advance) begin
      keyReg  <= nextRoundKey;
      // Runs 01 to 80, then wraps through 1B to 36
      rconReg <= aesDataPkg::xtime(rconReg);
    end
  end

  // A new key must never arrive while rounds are still running
  aLoadAdvanceExclusive: assert property (
    @(posedge clk) disable iff (rst) !(load && advance)
  );

endmodule

// ==== hdl/aesEncryptCore.sv ====
`timescale 1ns/1ns

module aesEncryptCore (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  aesDataPkg::aesBlock plainText,
  input  aesKeyPkg::aesKey    cipherKey,
  output aesDataPkg::aesBlock cipherText,
  output logic                done,
  output logic                busy
);

  aesKeyPkg::coreState ctrlState;
  aesKeyPkg::roundIdx  roundCnt;
  aesDataPkg::aesBlock stateReg;
  aesDataPkg::aesBlock roundOut;
  aesDataPkg::aesBlock nextRoundKey;
  logic                lastRound;
  logic                load;
  logic                advance;

  assign busy      = (ctrlState == aesKeyPkg::stRun);
  assign load      = start && !busy && !rst;
  assign advance   = busy;
  assign lastRound = (roundCnt == aesKeyPkg::numRounds);

  aesRoundFunc roundFunc_i (
    .stateIn  (stateReg),
    .roundKey (nextRoundKey),
    .lastRound(lastRound),
    .stateOut (roundOut)
  );

  aesKeyExpand keyExpand_i (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .advance     (advance),
    .cipherKey   (cipherKey),
    .nextRoundKey(nextRoundKey)
  );

  // Round counter holds the number of the round run at the next edge
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlState <= aesKeyPkg::stIdle;
      roundCnt  <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (ctrlState)
        aesKeyPkg::stIdle: begin
          if (load) begin
            ctrlState <= aesKeyPkg::stRun;
            roundCnt  <= 4'd1;
          end
        end
        aesKeyPkg::stRun: begin
          if (lastRound) begin
            ctrlState <= aesKeyPkg::stIdle;
            done      <= 1'b1;
          end else begin
            roundCnt <= roundCnt + 4'd1;
          end
        end
        default: begin
          ctrlState <= aesKeyPkg::stIdle;
        end
      endcase
    end
  end

  // Initial AddRoundKey on accept and one round per cycle after it
  always_ff @(posedge clk) begin
    if (load) begin
      stateReg <= plainText ^ cipherKey;
    end else if (advance) begin
      stateReg <= roundOut;
    end
  end

  // Result stays put until the next accepted start
  assign cipherText = stateReg;

  aDonePulse: assert property (
    @(posedge clk) disable iff (rst) done |=> !done
  );

  aRoundRange: assert property (
    @(posedge clk) disable iff (rst)
      busy |-> (roundCnt >= 4'd1) && (roundCnt <= aesKeyPkg::numRounds)
  );

  aDoneEndsBusy: assert property (
    @(posedge clk) disable iff (rst) done |-> $fell(busy)
  );

endmodule

// ==== dv/aesRefModel.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

// S-box values, filled once by buildRefSbox
aesDataPkg::aesByte refSbox [256];

// Carry-less product, then reduction by the full field polynomial
function automatic aesDataPkg::aesByte refMul(input aesDataPkg::aesByte a,
                                              input aesDataPkg::aesByte b);
  logic [15:0] prod;
  prod = 16'h0000;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) begin
      prod = prod ^ ({8'h00, a} << i);
    end
  end
  for (int i = 15; i >= 8; i--) begin
    if (prod[i]) begin
      prod = prod ^ (16'h011B << (i - 8));
    end
  end
  return prod[7:0];
endfunction

// Inverse found by search, then the bitwise affine map of FIPS-197 5.1.1
function automatic void buildRefSbox();
  aesDataPkg::aesByte inv;
  aesDataPkg::aesByte s;
  logic [7:0] c;
  c = 8'h63;
  for (int x = 0; x < 256; x++) begin
    inv = 8'h00;
    for (int y = 1; y < 256; y++) begin
      if (refMul(x[7:0], y[7:0]) == 8'h01) begin
        inv = y[7:0];
      end
    end
    for (int i = 0; i < 8; i++) begin
      s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
           ^ inv[(i + 7) % 8] ^ c[i];
    end
    refSbox[x] = s;
  end
endfunction

// State bytes are indexed row + 4 * column
function automatic aesDataPkg::aesBlock refEncrypt(input aesDataPkg::aesBlock pt,
                                                   input aesKeyPkg::aesKey key);
  aesDataPkg::aesByte st [16];
  aesDataPkg::aesByte tmp [16];
  aesDataPkg::aesByte w [176];
  aesDataPkg::aesByte rc;
  aesDataPkg::aesBlock res;
  for (int i = 0; i < 16; i++) begin
    w[i] = key[127 - 8 * i -: 8];
  end
  rc = 8'h01;
  for (int i = 16; i < 176; i += 4) begin
    if (i % 16 == 0) begin
      w[i]     = w[i - 16] ^ refSbox[w[i - 3]] ^ rc;
      w[i + 1] = w[i - 15] ^ refSbox[w[i - 2]];
      w[i + 2] = w[i - 14] ^ refSbox[w[i - 1]];
      w[i + 3] = w[i - 13] ^ refSbox[w[i - 4]];
      rc = refMul(rc, 8'h02);
    end else begin
      for (int j = 0; j < 4; j++) begin
        w[i + j] = w[i - 16 + j] ^ w[i - 4 + j];
      end
    end
  end
  for (int i = 0; i < 16; i++) begin
    st[i] = pt[127 - 8 * i -: 8] ^ w[i];
  end
  for (int r = 1; r <= 10; r++) begin
    for (int col = 0; col < 4; col++) begin
      for (int row = 0; row < 4; row++) begin
        tmp[row + 4 * col] = refSbox[st[row + 4 * ((col + row) % 4)]];
      end
    end
    if (r != 10) begin
      for (int col = 0; col < 4; col++) begin
        st[4 * col]     = refMul(tmp[4 * col], 8'h02) ^ refMul(tmp[4 * col + 1], 8'h03)
                        ^ tmp[4 * col + 2] ^ tmp[4 * col + 3];
        st[4 * col + 1] = tmp[4 * col] ^ refMul(tmp[4 * col + 1], 8'h02)
                        ^ refMul(tmp[4 * col + 2], 8'h03) ^ tmp[4 * col + 3];
        st[4 * col + 2] = tmp[4 * col] ^ tmp[4 * col + 1]
                        ^ refMul(tmp[4 * col + 2], 8'h02) ^ refMul(tmp[4 * col + 3], 8'h03);
        st[4 * col + 3] = refMul(tmp[4 * col], 8'h03) ^ tmp[4 * col + 1]
                        ^ tmp[4 * col + 2] ^ refMul(tmp[4 * col + 3], 8'h02);
      end
    end else begin
      st = tmp;
    end
    for (int i = 0; i < 16; i++) begin
      st[i] = st[i] ^ w[16 * r + i];
    end
  end
  for (int i = 0; i < 16; i++) begin
    res[127 - 8 * i -: 8] = st[i];
  end
  return res;
endfunction

`endif

// ==== dv/aesEncryptTb.sv ====
`timescale 1ns/1ns

module aesEncryptTb;

  `include "aesRefModel.svh"

  logic                clk;
  logic                rst;
  logic                start;
  aesDataPkg::aesBlock plainText;
  aesKeyPkg::aesKey    cipherKey;
  aesDataPkg::aesBlock cipherText;
  logic                done;
  logic                busy;

  integer seed;
  int     errorCount;
  int     testCount;

  aesEncryptCore aesEncryptCore_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .plainText (plainText),
    .cipherKey (cipherKey),
    .cipherText(cipherText),
    .done      (done),
    .busy      (busy)
  );

  always #2 clk = ~clk;

  task automatic checkBlock(input string what, input aesDataPkg::aesBlock got,
                            input aesDataPkg::aesBlock exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkLatency(input string what, input aesKeyPkg::roundIdx got,
                              input aesKeyPkg::roundIdx exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s, got %0d cycles, expected %0d", $time, what, got, exp);
      errorCount++;
    end
  endtask

  // Inputs change and outputs are read 1 ns after each rising edge
  task automatic stepCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic randomBlock(output aesDataPkg::aesBlock b);
    b[127:96] = $random(seed);
    b[95:64]  = $random(seed);
    b[63:32]  = $random(seed);
    b[31:0]   = $random(seed);
  endtask

  // Returns 1 ns after the edge that samples start
  task automatic startOp(input aesDataPkg::aesBlock pt, input aesKeyPkg::aesKey key);
    plainText = pt;
    cipherKey = key;
    start     = 1'b1;
    stepCycle();
    start = 1'b0;
  endtask

  task automatic waitDone(output int cycles);
    cycles = 0;
    while (cycles < 20 && done !== 1'b1) begin
      checkFlag("busy while waiting for done", busy, 1'b1);
      stepCycle();
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("Timeout: done did not rise within 20 cycles at %0t ns", $time);
      errorCount++;
    end else begin
      checkFlag("busy in the done cycle", busy, 1'b0);
    end
  endtask

  task automatic encryptCheck(input string what, input aesDataPkg::aesBlock pt,
                              input aesKeyPkg::aesKey key, input aesDataPkg::aesBlock exp);
    int cycles;
    startOp(pt, key);
    waitDone(cycles);
    checkBlock(what, cipherText, exp);
  endtask

  task automatic endTest(input string name, input int errBefore);
    testCount++;
    $display("Test %s finished with %0d errors", name, errorCount - errBefore);
  endtask

  task automatic testKnownAnswer();
    int errBefore;
    errBefore = errorCount;
    checkBlock("model, FIPS-197 B", refEncrypt(128'h3243f6a8885a308d313198a2e0370734,
               128'h2b7e151628aed2a6abf7158809cf4f3c), 128'h3925841d02dc09fbdc118597196a0b32);
    encryptCheck("FIPS-197 B", 128'h3243f6a8885a308d313198a2e0370734,
                 128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3925841d02dc09fbdc118597196a0b32);
    encryptCheck("FIPS-197 C.1", 128'h00112233445566778899aabbccddeeff,
                 128'h000102030405060708090a0b0c0d0e0f, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    endTest("knownAnswer", errBefore);
  endtask

  task automatic testRandom();
    int                  errBefore;
    aesDataPkg::aesBlock pt;
    aesDataPkg::aesBlock key;
    errBefore = errorCount;
    for (int n = 0; n < 20; n++) begin
      randomBlock(pt);
      randomBlock(key);
      encryptCheck("random vector", pt, key, refEncrypt(pt, key));
    end
    endTest("random", errBefore);
  endtask

  task automatic testLatencyHold();
    int                  errBefore;
    int                  cycles;
    aesDataPkg::aesBlock pt;
    aesDataPkg::aesBlock key;
    aesDataPkg::aesBlock held;
    errBefore = errorCount;
    randomBlock(pt);
    randomBlock(key);
    startOp(pt, key);
    waitDone(cycles);
    checkLatency("done latency", aesKeyPkg::roundIdx'(cycles), 4'd10);
    checkBlock("latency result", cipherText, refEncrypt(pt, key));
    held = cipherText;
    repeat (6) begin
      stepCycle();
      checkFlag("done after its pulse", done, 1'b0);
      checkBlock("held ciphertext", cipherText, held);
    end
    endTest("latencyHold", errBefore);
  endtask

  task automatic testBackToBack();
    int                  errBefore;
    int                  cycles;
    aesDataPkg::aesBlock ptA;
    aesDataPkg::aesBlock keyA;
    aesDataPkg::aesBlock ptB;
    aesDataPkg::aesBlock keyB;
    errBefore = errorCount;
    randomBlock(ptA);
    randomBlock(keyA);
    randomBlock(ptB);
    randomBlock(keyB);
    startOp(ptA, keyA);
    waitDone(cycles);
    checkBlock("first of back-to-back", cipherText, refEncrypt(ptA, keyA));
    // Start lands in the done cycle
    startOp(ptB, keyB);
    waitDone(cycles);
    checkLatency("second start latency", aesKeyPkg::roundIdx'(cycles), 4'd10);
    checkBlock("second of back-to-back", cipherText, refEncrypt(ptB, keyB));
    endTest("backToBack", errBefore);
  endtask

  task automatic testIgnoredStart();
    int                  errBefore;
    int                  cycles;
    aesDataPkg::aesBlock ptA;
    aesDataPkg::aesBlock keyA;
    errBefore = errorCount;
    randomBlock(ptA);
    randomBlock(keyA);
    startOp(ptA, keyA);
    repeat (3) stepCycle();
    plainText = ~ptA;
    cipherKey = ~keyA;
    start     = 1'b1;
    stepCycle();
    start = 1'b0;
    waitDone(cycles);
    checkLatency("done with a stray start", aesKeyPkg::roundIdx'(cycles + 4), 4'd10);
    checkBlock("result with a stray start", cipherText, refEncrypt(ptA, keyA));
    stepCycle();
    checkFlag("busy after the stray start", busy, 1'b0);
    endTest("ignoredStart", errBefore);
  endtask

  task automatic testResetMid();
    int                  errBefore;
    aesDataPkg::aesBlock pt;
    aesDataPkg::aesBlock key;
    errBefore = errorCount;
    randomBlock(pt);
    randomBlock(key);
    startOp(pt, key);
    // Reset covers the edges of rounds 9 and 10, where done would rise
    repeat (8) stepCycle();
    rst = 1'b1;
    stepCycle();
    checkFlag("busy in reset", busy, 1'b0);
    stepCycle();
    checkFlag("done in reset", done, 1'b0);
    rst = 1'b0;
    repeat (12) begin
      stepCycle();
      checkFlag("done after reset", done, 1'b0);
      checkFlag("busy after reset", busy, 1'b0);
    end
    randomBlock(pt);
    randomBlock(key);
    encryptCheck("encryption after reset", pt, key, refEncrypt(pt, key));
    endTest("resetMid", errBefore);
  endtask

  initial begin
    seed       = 17174;
    errorCount = 0;
    testCount  = 0;
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    plainText  = '0;
    cipherKey  = '0;
    buildRefSbox();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    stepCycle();
    testKnownAnswer();
    testRandom();
    testLatencyHold();
    testBackToBack();
    testIgnoredStart();
    testResetMid();
    $display("Tests run: %0d, errors: %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== aesEncrypt.f ====
+incdir+dv
hdl/aesDataPkg.sv
hdl/aesKeyPkg.sv
hdl/aesSbox.sv
hdl/aesRoundFunc.sv
hdl/aesKeyExpand.sv
hdl/aesEncryptCore.sv
dv/aesEncryptTb.sv

// ==== Bender.yml ====
package:
  name: aesEncrypt

sources:
  - files:
      - hdl/aesDataPkg.sv
      - hdl/aesKeyPkg.sv
      - hdl/aesSbox.sv
      - hdl/aesRoundFunc.sv
      - hdl/aesKeyExpand.sv
      - hdl/aesEncryptCore.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/aesEncryptTb.sv
